//--- flist.f
+incdir+verif
design/cgraPkg.sv
design/dtlSlave.sv
design/dtlReadMaster.sv
design/controlRegs.sv
design/configLoader.sv
design/cgraControlWrapper.sv
verif/tbCgraControlWrapper.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tbCgraControlWrapper > build.log 2>&1 \
	&& ./obj_dir/VtbCgraControlWrapper > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verif/tbSharedMemModel.svh
`ifndef TB_SHARED_MEM_MODEL_SVH
`define TB_SHARED_MEM_MODEL_SVH

// a count header sits on every 256-byte boundary with the image words after it
localparam int imageCount = 6;

logic [31:0] memLcg = 32'h2257;

function automatic logic [31:0] lcgNext(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// junk above the count field of the header must be ignored by the loader
function automatic logic [31:0] imageWord(input logic [31:0] addr);
	if (addr[7:0] == 8'h00)
		return 32'hABC0_0000 | imageCount;
	return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
endfunction

// answers one single-beat read at a time with random accept and data latency
initial
begin
	logic [31:0] fetchAddr;
	int acceptDelay;
	int dataDelay;
	forever
	begin
		@(negedge iClk);
		if (rstN && smemCommandValid)
		begin
			assert (smemCommandReadWrite)
			else
				mismatch("smemCommandReadWrite", 32'(smemCommandReadWrite), 1);
			// the write side of the master stays idle
			assert (!smemWriteValid)
			else
				mismatch("smemWriteValid", 32'(smemWriteValid), 0);
			assert (smemWriteEnable == '0)
			else
				mismatch("smemWriteEnable", 32'(smemWriteEnable), 0);
			assert (!smemWriteLast)
			else
				mismatch("smemWriteLast", 32'(smemWriteLast), 0);
			assert (smemWriteData == '0)
			else
				mismatch("smemWriteData", smemWriteData, 0);
			fetchAddr = smemAddress;
			memLcg = lcgNext(memLcg);
			acceptDelay = memLcg[17:16];
			dataDelay = memLcg[21:20];
			repeat (acceptDelay) @(posedge iClk);
			@(posedge iClk);
			smemCommandAccept <= 1'b1;
			@(negedge iClk);
			assert (smemCommandValid)
			else
				mismatch("smemCommandValid", 32'(smemCommandValid), 1);
			assert (smemAddress == fetchAddr)
			else
				mismatch("smemAddress", smemAddress, fetchAddr);
			@(posedge iClk);
			smemCommandAccept <= 1'b0;
			repeat (dataDelay) @(posedge iClk);
			smemReadValid <= 1'b1;
			smemReadLast <= 1'b1;
			smemReadData <= imageWord(fetchAddr);
			@(negedge iClk);
			assert (smemReadAccept)
			else
				mismatch("smemReadAccept", 32'(smemReadAccept), 1);
			@(posedge iClk);
			smemReadValid <= 1'b0;
			smemReadLast <= 1'b0;
		end
	end
end

`endif

//--- verif/tbCgraControlWrapper.sv
module tbCgraControlWrapper;

	localparam cgraPkg::dtlAddr regionBase = 32'hC0000;
	localparam int imAddrWidth = 8;
	// two loads and about thirty host accesses take well under a thousand cycles
	localparam int timeoutCycles = 20000;

	logic iClk = 1'b0;
	logic rstN;
	logic halted;
	logic stall;

	logic commandValid;
	logic commandAccept;
	cgraPkg::dtlAddr address;
	logic commandReadWrite;
	logic writeValid;
	logic writeAccept;
	cgraPkg::dtlWord writeData;
	logic [cgraPkg::enableWidth-1:0] writeEnable;
	logic writeLast;
	logic readValid;
	logic readLast;
	logic readAccept;
	cgraPkg::dtlWord readData;

	logic smemCommandValid;
	logic smemCommandAccept;
	cgraPkg::dtlAddr smemAddress;
	logic smemCommandReadWrite;
	logic smemWriteValid;
	cgraPkg::dtlWord smemWriteData;
	logic [cgraPkg::enableWidth-1:0] smemWriteEnable;
	logic smemWriteLast;
	logic smemReadValid;
	logic smemReadAccept;
	logic smemReadLast;
	cgraPkg::dtlWord smemReadData;

	logic coreReset;
	logic configDone;
	logic imWriteEnable;
	logic [imAddrWidth-1:0] imWriteAddress;
	cgraPkg::dtlWord imWriteData;

	logic [31:0] hostLcg = 32'h2257;
	logic [31:0] loadBaseRef;
	int expectedCount;
	int writeCount;
	int stallExpected;
	int elapsedCycles = 0;
	int errorCount = 0;

	always #50 iClk = ~iClk;

	cgraControlWrapper #(
		.loaderOffset(regionBase),
		.imAddrWidth(imAddrWidth)
	) UUT (.*);

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		errorCount++;
		$display("CHECK FAILED at time %0t: %s is %h, reference %h", $time, name, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic failRun(input string reason);
		errorCount++;
		$display("ERROR at time %0t: %s", $time, reason);
		$display("=== FAIL ===");
		$fatal(1, "stopping at the first error");
	endtask

	`include "tbSharedMemModel.svh"

	// status word as the register map defines it
	function automatic logic [31:0] statusWord(input logic done, input logic isHalted,
		input logic inReset, input logic isStall);
		logic [31:0] s;
		s = '0;
		s[cgraPkg::statusConfigDone] = done;
		s[cgraPkg::statusHalted] = isHalted;
		s[cgraPkg::statusReset] = inReset;
		s[cgraPkg::statusStall] = isStall;
		return s;
	endfunction

	task automatic hostWrite(input logic [31:0] offset, input logic [31:0] data);
		@(posedge iClk);
		commandValid <= 1'b1;
		commandReadWrite <= 1'b0;
		address <= regionBase + offset;
		writeValid <= 1'b1;
		writeData <= data;
		writeEnable <= '1;
		writeLast <= 1'b1;
		@(negedge iClk);
		while (!commandAccept)
			@(negedge iClk);
		@(posedge iClk);
		commandValid <= 1'b0;
		@(negedge iClk);
		while (!writeAccept)
			@(negedge iClk);
		@(posedge iClk);
		writeValid <= 1'b0;
		writeLast <= 1'b0;
	endtask

	// the response must hold still until readAccept, which comes after a random hold
	task automatic hostRead(input logic [31:0] offset, output logic [31:0] data);
		int holdCycles;
		logic [31:0] firstData;
		@(posedge iClk);
		commandValid <= 1'b1;
		commandReadWrite <= 1'b1;
		address <= regionBase + offset;
		@(negedge iClk);
		while (!commandAccept)
			@(negedge iClk);
		@(posedge iClk);
		commandValid <= 1'b0;
		@(negedge iClk);
		while (!readValid)
			@(negedge iClk);
		firstData = readData;
		hostLcg = lcgNext(hostLcg);
		holdCycles = hostLcg[18:16];
		repeat (holdCycles)
		begin
			@(negedge iClk);
			assert (readValid) else mismatch("readValid", 32'(readValid), 1);
			assert (readData == firstData) else mismatch("readData", readData, firstData);
		end
		assert (readLast) else mismatch("readLast", 32'(readLast), 1);
		@(posedge iClk);
		readAccept <= 1'b1;
		@(negedge iClk);
		assert (readValid) else mismatch("readValid", 32'(readValid), 1);
		assert (readData == firstData) else mismatch("readData", readData, firstData);
		@(posedge iClk);
		readAccept <= 1'b0;
		data = firstData;
	endtask

	// compares every instruction-memory write with the reference image
	always @(negedge iClk)
	begin
		if (rstN && imWriteEnable)
		begin
			assert (writeCount < expectedCount)
			else
				failRun("more instruction-memory writes than the header count");
			assert (imWriteAddress == writeCount[imAddrWidth-1:0])
			else
				mismatch("imWriteAddress", 32'(imWriteAddress), writeCount);
			assert (imWriteData == imageWord(loadBaseRef + 32'(4 * (writeCount + 1))))
			else
				mismatch("imWriteData", imWriteData,
					imageWord(loadBaseRef + 32'(4 * (writeCount + 1))));
			writeCount = writeCount + 1;
		end
	end

	// stall levels are sampled where the DUT's next edge sees them
	always @(negedge iClk)
	begin
		if (!rstN || coreReset)
			stallExpected <= 0;
		else if (!halted && stall)
			stallExpected <= stallExpected + 1;
	end

	always @(posedge iClk)
	begin
		elapsedCycles <= elapsedCycles + 1;
		if (elapsedCycles >= timeoutCycles)
			failRun("timeout, the run did not finish within the cycle limit");
	end

	initial
	begin
		logic [31:0] value;
		logic [31:0] first;
		logic [31:0] second;
		rstN = 1'b0;
		halted = 1'b0;
		stall = 1'b0;
		commandValid = 1'b0;
		address = '0;
		commandReadWrite = 1'b0;
		writeValid = 1'b0;
		writeData = '0;
		writeEnable = '0;
		writeLast = 1'b0;
		readAccept = 1'b0;
		smemCommandAccept = 1'b0;
		smemReadValid = 1'b0;
		smemReadLast = 1'b0;
		smemReadData = '0;
		loadBaseRef = '0;
		expectedCount = 0;
		writeCount = 0;
		repeat (5) @(posedge iClk);
		rstN <= 1'b1;

		// state right after reset
		hostRead(cgraPkg::regStatusOffset, value);
		assert (value == statusWord(0, 0, 1, 0))
		else
			mismatch("status", value, statusWord(0, 0, 1, 0));
		@(negedge iClk);
		assert (coreReset) else mismatch("coreReset", 32'(coreReset), 1);
		assert (!imWriteEnable) else mismatch("imWriteEnable", 32'(imWriteEnable), 0);

		// the second start of this load lands while the loader is busy
		loadBaseRef = 32'h0001_0000;
		expectedCount = imageWord(loadBaseRef) & 32'h1FF;
		writeCount = 0;
		hostWrite(cgraPkg::regStatusOffset, loadBaseRef);
		hostWrite(cgraPkg::regStatusOffset, 32'h0002_0000);
		@(negedge iClk);
		assert (!configDone) else failRun("load finished before the second start was issued");
		while (!configDone)
			@(negedge iClk);
		repeat (10) @(negedge iClk);
		assert (writeCount == expectedCount)
		else
			mismatch("imWriteCount", writeCount, expectedCount);
		hostRead(cgraPkg::regStatusOffset, value);
		assert (value == statusWord(1, 0, 1, 0))
		else
			mismatch("status", value, statusWord(1, 0, 1, 0));

		// core-reset register
		hostWrite(cgraPkg::regResetOffset, 32'h0);
		@(negedge iClk);
		assert (!coreReset) else mismatch("coreReset", 32'(coreReset), 0);
		hostRead(cgraPkg::regStatusOffset, value);
		assert (value == statusWord(1, 0, 0, 0))
		else
			mismatch("status", value, statusWord(1, 0, 0, 0));
		hostWrite(cgraPkg::regResetOffset, 32'h1);
		@(negedge iClk);
		assert (coreReset) else mismatch("coreReset", 32'(coreReset), 1);
		hostRead(cgraPkg::regResetOffset, value);
		assert (value == 0) else mismatch("cycleCount", value, 0);
		hostRead(cgraPkg::regStallOffset, value);
		assert (value == 0) else mismatch("stallCount", value, 0);

		// cycle counter freezes while halted and the stall level shows in status
		@(posedge iClk);
		halted <= 1'b1;
		stall <= 1'b1;
		hostWrite(cgraPkg::regResetOffset, 32'h0);
		hostRead(cgraPkg::regStatusOffset, value);
		assert (value == statusWord(1, 1, 0, 1))
		else
			mismatch("status", value, statusWord(1, 1, 0, 1));
		hostRead(cgraPkg::regResetOffset, first);
		hostRead(cgraPkg::regResetOffset, second);
		assert (second == first) else mismatch("cycleCount", second, first);
		@(posedge iClk);
		halted <= 1'b0;
		stall <= 1'b0;
		hostRead(cgraPkg::regResetOffset, first);
		hostRead(cgraPkg::regResetOffset, second);
		assert (second > first) else mismatch("cycleCount", second, first);

		// stall counter against a random stall pattern after a fresh clear
		hostWrite(cgraPkg::regResetOffset, 32'h1);
		hostWrite(cgraPkg::regResetOffset, 32'h0);
		for (int i = 0; i < 40; i++)
		begin
			@(posedge iClk);
			hostLcg = lcgNext(hostLcg);
			stall <= hostLcg[20];
		end
		@(posedge iClk);
		stall <= 1'b0;
		hostRead(cgraPkg::regStallOffset, value);
		assert (value == stallExpected) else mismatch("stallCount", value, stallExpected);

		// a load on a running core holds it in reset until the image is written
		loadBaseRef = 32'h0003_0000;
		expectedCount = imageWord(loadBaseRef) & 32'h1FF;
		writeCount = 0;
		hostWrite(cgraPkg::regStatusOffset, loadBaseRef);
		@(negedge iClk);
		assert (coreReset) else mismatch("coreReset", 32'(coreReset), 1);
		while (!configDone)
			@(negedge iClk);
		repeat (10) @(negedge iClk);
		assert (writeCount == expectedCount)
		else
			mismatch("imWriteCount", writeCount, expectedCount);
		assert (!coreReset) else mismatch("coreReset", 32'(coreReset), 0);

		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- design/cgraControlWrapper.sv
module cgraControlWrapper
#(
	parameter cgraPkg::dtlAddr loaderOffset = 32'hC0000,
	parameter int imAddrWidth = 8
)
(
	input logic iClk,
	input logic rstN,
	input logic halted,
	input logic stall,

	// host DTL slave port
	input logic commandValid,
	output logic commandAccept,
	input cgraPkg::dtlAddr address,
	input logic commandReadWrite,
	input logic writeValid,
	output logic writeAccept,
	input cgraPkg::dtlWord writeData,
	input logic [cgraPkg::enableWidth-1:0] writeEnable,
	input logic writeLast,
	output logic readValid,
	output logic readLast,
	input logic readAccept,
	output cgraPkg::dtlWord readData,

	// shared memory DTL master port
	output logic smemCommandValid,
	input logic smemCommandAccept,
	output cgraPkg::dtlAddr smemAddress,
	output logic smemCommandReadWrite,
	output logic smemWriteValid,
	output cgraPkg::dtlWord smemWriteData,
	output logic [cgraPkg::enableWidth-1:0] smemWriteEnable,
	output logic smemWriteLast,
	input logic smemReadValid,
	output logic smemReadAccept,
	input logic smemReadLast,
	input cgraPkg::dtlWord smemReadData,

	output logic coreReset,
	output logic configDone,
	output logic imWriteEnable,
	output logic [imAddrWidth-1:0] imWriteAddress,
	output cgraPkg::dtlWord imWriteData
);

	logic regWrite;
	cgraPkg::dtlAddr regOffset;
	cgraPkg::dtlWord regWriteData;
	cgraPkg::dtlWord regReadData;
	logic loadStart;
	cgraPkg::dtlWord loadBase;
	logic loaderReset;
	logic fetchRequest;
	cgraPkg::dtlAddr fetchAddress;
	logic fetchValid;
	cgraPkg::dtlWord fetchData;

	dtlSlave #(
		.loaderOffset(loaderOffset)
	) hostSlave (
		.iClk(iClk), .rstN(rstN),
		.commandValid(commandValid), .commandAccept(commandAccept),
		.address(address), .commandReadWrite(commandReadWrite),
		.writeValid(writeValid), .writeAccept(writeAccept), .writeData(writeData),
		.writeEnable(writeEnable), .writeLast(writeLast),
		.readValid(readValid), .readLast(readLast), .readAccept(readAccept),
		.readData(readData),
		.regWrite(regWrite), .regOffset(regOffset), .regWriteData(regWriteData),
		.regReadData(regReadData)
	);

	controlRegs regs (
		.iClk(iClk), .rstN(rstN),
		.regWrite(regWrite), .regOffset(regOffset), .regWriteData(regWriteData),
		.regReadData(regReadData),
		.loaderReset(loaderReset), .configDone(configDone),
		.loadStart(loadStart), .loadBase(loadBase),
		.halted(halted), .stall(stall), .coreReset(coreReset)
	);

	configLoader #(
		.imAddrWidth(imAddrWidth)
	) loader (
		.iClk(iClk), .rstN(rstN),
		.loadStart(loadStart), .loadBase(loadBase),
		.fetchRequest(fetchRequest), .fetchAddress(fetchAddress),
		.fetchValid(fetchValid), .fetchData(fetchData),
		.loaderReset(loaderReset), .configDone(configDone),
		.imWriteEnable(imWriteEnable), .imWriteAddress(imWriteAddress),
		.imWriteData(imWriteData)
	);

	dtlReadMaster smemMaster (
		.iClk(iClk), .rstN(rstN),
		.fetchRequest(fetchRequest), .fetchAddress(fetchAddress),
		.fetchValid(fetchValid), .fetchData(fetchData),
		.smemCommandValid(smemCommandValid), .smemCommandAccept(smemCommandAccept),
		.smemAddress(smemAddress), .smemCommandReadWrite(smemCommandReadWrite),
		.smemWriteValid(smemWriteValid), .smemWriteData(smemWriteData),
		.smemWriteEnable(smemWriteEnable), .smemWriteLast(smemWriteLast),
		.smemReadValid(smemReadValid), .smemReadAccept(smemReadAccept),
		.smemReadLast(smemReadLast), .smemReadData(smemReadData)
	);

endmodule

//--- design/configLoader.sv
module configLoader
#(
	parameter int imAddrWidth = 8
)
(
	input logic iClk,
	input logic rstN,

	// start from the register map
	input logic loadStart,
	input cgraPkg::dtlWord loadBase,

	// shared memory fetches
	output logic fetchRequest,
	output cgraPkg::dtlAddr fetchAddress,
	input logic fetchValid,
	input cgraPkg::dtlWord fetchData,

	// status
	output logic loaderReset,
	output logic configDone,

	// instruction memory write port
	output logic imWriteEnable,
	output logic [imAddrWidth-1:0] imWriteAddress,
	output cgraPkg::dtlWord imWriteData
);

	typedef enum logic [1:0] {stIdle, stHeader, stBody} stateType;

	stateType state;
	logic [imAddrWidth:0] wordCount;
	logic [imAddrWidth:0] wordIndex;
	logic [imAddrWidth:0] nextIndex;
	logic [imAddrWidth:0] headerCount;

	assign nextIndex = wordIndex + 1'b1;
	assign headerCount = fetchData[imAddrWidth:0];

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			fetchRequest <= 1'b0;
			loaderReset <= 1'b0;
			configDone <= 1'b0;
			imWriteEnable <= 1'b0;
		end
		else
		begin
			fetchRequest <= 1'b0;
			imWriteEnable <= 1'b0;
			case (state)
				// starts while busy are dropped here
				stIdle:
					if (loadStart)
					begin
						loaderReset <= 1'b1;
						configDone <= 1'b0;
						fetchRequest <= 1'b1;
						state <= stHeader;
					end
				stHeader:
					if (fetchValid)
					begin
						if (headerCount == '0)
						begin
							loaderReset <= 1'b0;
							configDone <= 1'b1;
							state <= stIdle;
						end
						else
						begin
							fetchRequest <= 1'b1;
							state <= stBody;
						end
					end
				stBody:
					if (fetchValid)
					begin
						imWriteEnable <= 1'b1;
						if (nextIndex == wordCount)
						begin
							loaderReset <= 1'b0;
							configDone <= 1'b1;
							state <= stIdle;
						end
						else
							fetchRequest <= 1'b1;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge iClk)
	begin
		if (state == stIdle && loadStart)
			fetchAddress <= loadBase;
		if (state == stHeader && fetchValid)
		begin
			wordCount <= headerCount;
			wordIndex <= '0;
			fetchAddress <= fetchAddress + 'd4;
		end
		// image words follow the header back to back
		if (state == stBody && fetchValid)
		begin
			imWriteAddress <= wordIndex[imAddrWidth-1:0];
			imWriteData <= fetchData;
			wordIndex <= nextIndex;
			fetchAddress <= fetchAddress + 'd4;
		end
	end

endmodule

//--- design/controlRegs.sv
module controlRegs
(
	input logic iClk,
	input logic rstN,

	// register access from the slave
	input logic regWrite,
	input cgraPkg::dtlAddr regOffset,
	input cgraPkg::dtlWord regWriteData,
	output cgraPkg::dtlWord regReadData,

	// loader
	input logic loaderReset,
	input logic configDone,
	output logic loadStart,
	output cgraPkg::dtlWord loadBase,

	// core
	input logic halted,
	input logic stall,
	output logic coreReset
);

	logic coreResetReg;
	logic running;
	cgraPkg::dtlWord cycleCount;
	cgraPkg::dtlWord stallCount;
	cgraPkg::dtlWord status;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			coreResetReg <= 1'b1;
		else if (regWrite && regOffset == cgraPkg::regResetOffset)
			coreResetReg <= regWriteData[0];
	end

	assign coreReset = loaderReset | coreResetReg;
	assign running = !coreReset && !halted;

	// performance counters only run while the core runs
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cycleCount <= '0;
			stallCount <= '0;
		end
		else if (coreReset)
		begin
			cycleCount <= '0;
			stallCount <= '0;
		end
		else
		begin
			if (running)
				cycleCount <= cycleCount + 1'b1;
			if (running && stall)
				stallCount <= stallCount + 1'b1;
		end
	end

	assign loadStart = regWrite && (regOffset == cgraPkg::regStatusOffset);
	assign loadBase = regWriteData;

	always_comb
	begin
		status = '0;
		status[cgraPkg::statusConfigDone] = configDone;
		status[cgraPkg::statusHalted] = halted;
		status[cgraPkg::statusReset] = coreReset;
		status[cgraPkg::statusStall] = stall;
	end

	always_comb
	begin
		case (regOffset)
			cgraPkg::regStatusOffset:
				regReadData = status;
			cgraPkg::regResetOffset:
				regReadData = cycleCount;
			cgraPkg::regStallOffset:
				regReadData = stallCount;
			default:
				regReadData = '0;
		endcase
	end

endmodule

//--- design/dtlReadMaster.sv
module dtlReadMaster
(
	input logic iClk,
	input logic rstN,

	// fetch side
	input logic fetchRequest,
	input cgraPkg::dtlAddr fetchAddress,
	output logic fetchValid,
	output cgraPkg::dtlWord fetchData,

	// shared memory side
	output logic smemCommandValid,
	input logic smemCommandAccept,
	output cgraPkg::dtlAddr smemAddress,
	output logic smemCommandReadWrite,
	output logic smemWriteValid,
	output cgraPkg::dtlWord smemWriteData,
	output logic [cgraPkg::enableWidth-1:0] smemWriteEnable,
	output logic smemWriteLast,
	input logic smemReadValid,
	output logic smemReadAccept,
	input logic smemReadLast,
	input cgraPkg::dtlWord smemReadData
);

	typedef enum logic [1:0] {stIdle, stCommand, stRead} stateType;

	stateType state;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			fetchValid <= 1'b0;
		end
		else
		begin
			fetchValid <= (state == stRead) && smemReadValid && smemReadLast;
			case (state)
				stIdle:
					if (fetchRequest)
						state <= stCommand;
				stCommand:
					if (smemCommandAccept)
						state <= stRead;
				stRead:
					if (smemReadValid && smemReadLast)
						state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge iClk)
	begin
		if (state == stIdle && fetchRequest)
			smemAddress <= fetchAddress;
		if (state == stRead && smemReadValid)
			fetchData <= smemReadData;
	end

	assign smemCommandValid = (state == stCommand);
	assign smemReadAccept = (state == stRead);

	// read-only master
	assign smemCommandReadWrite = 1'b1;
	assign smemWriteValid = 1'b0;
	assign smemWriteData = '0;
	assign smemWriteEnable = '0;
	assign smemWriteLast = 1'b0;

endmodule

//--- design/dtlSlave.sv
module dtlSlave
#(
	parameter cgraPkg::dtlAddr loaderOffset = 32'hC0000
)
(
	input logic iClk,
	input logic rstN,

	// host side
	input logic commandValid,
	output logic commandAccept,
	input cgraPkg::dtlAddr address,
	input logic commandReadWrite,
	input logic writeValid,
	output logic writeAccept,
	input cgraPkg::dtlWord writeData,
	input logic [cgraPkg::enableWidth-1:0] writeEnable,
	input logic writeLast,
	output logic readValid,
	output logic readLast,
	input logic readAccept,
	output cgraPkg::dtlWord readData,

	// register side
	output logic regWrite,
	output cgraPkg::dtlAddr regOffset,
	output cgraPkg::dtlWord regWriteData,
	input cgraPkg::dtlWord regReadData
);

	typedef enum logic [1:0] {stIdle, stAccept, stWriteWait, stReadHold} stateType;

	stateType state;
	cgraPkg::dtlAddr commandAddress;
	logic commandIsRead;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			state <= stIdle;
		else
		begin
			case (state)
				stIdle:
					if (commandValid)
						state <= stAccept;
				stAccept:
					state <= commandIsRead ? stReadHold : stWriteWait;
				// extra beats are absorbed until the last one
				stWriteWait:
					if (writeValid && writeLast)
						state <= stIdle;
				stReadHold:
					if (readAccept)
						state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge iClk)
	begin
		if (state == stIdle && commandValid)
		begin
			commandAddress <= address;
			commandIsRead <= commandReadWrite;
		end
		// sample once, then hold while the host stalls
		if (state == stAccept && commandIsRead)
			readData <= regReadData;
	end

	assign commandAccept = (state == stAccept);
	assign writeAccept = (state == stWriteWait) && writeValid;
	assign regWrite = writeAccept;
	assign readValid = (state == stReadHold);
	assign readLast = readValid;
	assign regOffset = commandAddress - loaderOffset;

	// disabled byte lanes write as zero
	always_comb
	begin
		for (int i = 0; i < cgraPkg::enableWidth; i++)
		begin
			regWriteData[8*i +: 8] = writeEnable[i] ? writeData[8*i +: 8] : 8'h00;
		end
	end

endmodule

//--- design/cgraPkg.sv
package cgraPkg;

	// host and shared-memory bus widths
	parameter int dataWidth = 32;
	parameter int addrWidth = 32;

	typedef logic [dataWidth-1:0] dtlWord;
	typedef logic [addrWidth-1:0] dtlAddr;

	// one write enable per byte lane
	parameter int enableWidth = dataWidth / 8;

	// register offsets relative to the register window base
	// write starts the loader, read returns status
	parameter dtlAddr regStatusOffset = 32'h0;

	// write sets core reset, read returns the cycle counter
	parameter dtlAddr regResetOffset = 32'h4;

	// read returns the stall counter
	parameter dtlAddr regStallOffset = 32'h8;

	// status word bit positions
	parameter int statusConfigDone = 0;
	parameter int statusHalted = 1;
	parameter int statusReset = 2;
	parameter int statusStall = 3;

endpackage
